/* core_trace.txt */
# I <addr> <word> : program memory word, hex
# R <pc> <instr> <rd> <we> <rd_data> : expected retire record in order, hex
I 80000000 00500093
I 80000004 ffd00113
I 80000008 002081b3
I 8000000c 40118233
I 80000010 40125293
I 80000014 0012a333
I 80000018 12345437
I 8000001c 00001517
I 80000020 00708013
I 80000024 001005b3
I 80000028 00b08463
I 8000002c 06300613
I 80000030 008006ef
I 80000034 06200613
I 80000038 00d687e7
I 8000003c 06100613
I 80000040 0082f633
I 80000044 0000006f
R 80000000 00500093 01 1 00000005
R 80000004 ffd00113 02 1 fffffffd
R 80000008 002081b3 03 1 00000002
R 8000000c 40118233 04 1 fffffffd
R 80000010 40125293 05 1 fffffffe
R 80000014 0012a333 06 1 00000001
R 80000018 12345437 08 1 12345000
R 8000001c 00001517 0a 1 8000101c
R 80000020 00708013 00 1 0000000c
R 80000024 001005b3 0b 1 00000005
R 80000028 00b08463 08 0 00000000
R 80000030 008006ef 0d 1 80000034
R 80000038 00d687e7 0f 1 8000003c
R 80000040 0082f633 0c 1 12345000
R 80000044 0000006f 00 1 80000048
R 80000044 0000006f 00 1 80000048

/* list.f */
+incdir+.
rv_pkg.sv
fetch_unit.sv
decode_unit.sv
reg_file.sv
exec_unit.sv
pipe_ctrl.sv
core_top.sv
core_props.sv
tb_core.sv

/* tb_core.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rv_consts.svh"

module tb_core
    import rv_pkg::*;
();

    localparam int MEM_WORDS      = 64;
    localparam int START_TIMEOUT  = 10;
    localparam int RETIRE_TIMEOUT = 100;

    logic             clk;
    logic             rstn;
    logic             wb_cyc;
    logic             wb_stb;
    logic [`XLEN-1:0] wb_adr;
    logic [`XLEN-1:0] wb_dat;
    logic             wb_ack;
    retire_s          retire;

    logic [31:0] prog [MEM_WORDS];
    logic [31:0] exp_pc [$];
    logic [31:0] exp_instr [$];
    logic [31:0] exp_rd [$];
    logic [31:0] exp_we [$];
    logic [31:0] exp_data [$];

    logic [31:0] seed;
    logic        busy;
    int          waits;
    int          errors;
    int          checks;
    int          next_idx;
    int          idle;

    core_top dut_i (
        .clk      (clk),
        .rstn     (rstn),
        .wb_cyc_o (wb_cyc),
        .wb_stb_o (wb_stb),
        .wb_adr_o (wb_adr),
        .wb_dat_i (wb_dat),
        .wb_ack_i (wb_ack),
        .retire_o (retire)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Unloaded words differ for every address
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return addr ^ 32'h3c5a_96e1;
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - `RESET_PC) >> 2;
        if (idx < MEM_WORDS) begin
            return prog[idx];
        end
        return fill_word(addr);
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic load_trace();
        int          fd;
        int          c;
        int          n;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        logic [31:0] f5;
        for (int i = 0; i < MEM_WORDS; i++) begin
            prog[i] = fill_word(`RESET_PC + 4 * i);
        end
        fd = $fopen("core_trace.txt", "r");
        if (fd == 0) begin
            $display("Error at %0t: cannot open core_trace.txt", $time);
            errors++;
            return;
        end
        c = $fgetc(fd);
        while (c != -1) begin
            if (c == "#") begin
                while (c != "\n" && c != -1) begin
                    c = $fgetc(fd);
                end
            end else if (c == "I") begin
                n = $fscanf(fd, "%h %h", f1, f2);
                if (n == 2 && ((f1 - `RESET_PC) >> 2) < MEM_WORDS) begin
                    prog[(f1 - `RESET_PC) >> 2] = f2;
                end else begin
                    $display("Error: program line in the trace is malformed or out of range");
                    errors++;
                end
            end else if (c == "R") begin
                n = $fscanf(fd, "%h %h %h %h %h", f1, f2, f3, f4, f5);
                if (n == 5) begin
                    exp_pc.push_back(f1);
                    exp_instr.push_back(f2);
                    exp_rd.push_back(f3);
                    exp_we.push_back(f4);
                    exp_data.push_back(f5);
                end else begin
                    $display("Error: retire line in the trace is malformed");
                    errors++;
                end
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
        if (exp_pc.size() == 0) begin
            $display("Error: the trace holds no expected retires");
            errors++;
        end
    endtask

    // Wishbone slave with 0 to 3 wait states per transfer
    task automatic serve_bus();
        if (wb_ack) begin
            busy = 1'b0;
        end
        if (!busy && wb_cyc && wb_stb) begin
            seed  = next_rand(seed);
            waits = int'(seed[17:16]);
            busy  = 1'b1;
        end
        if (busy && waits == 0) begin
            wb_ack = 1'b1;
            wb_dat = read_word(wb_adr);
        end else begin
            wb_ack = 1'b0;
            if (busy) begin
                waits--;
            end
        end
    endtask

    task automatic check_retire();
        if (!retire.valid) begin
            idle++;
            return;
        end
        idle = 0;
        if (next_idx >= exp_pc.size()) begin
            return;
        end
        check_val("retire_o.pc", retire.pc, exp_pc[next_idx]);
        check_val("retire_o.instr", retire.instr, exp_instr[next_idx]);
        check_val("retire_o.rd", retire.rd, exp_rd[next_idx]);
        check_val("retire_o.we", retire.we, exp_we[next_idx]);
        check_val("retire_o.rd_data", retire.rd_data, exp_data[next_idx]);
        next_idx++;
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #2;
        check_retire();
        serve_bus();
    endtask

    initial begin
        int start_cnt;
        rstn     = 1'b0;
        wb_ack   = 1'b0;
        wb_dat   = '0;
        seed     = 32'h7927bc08;
        busy     = 1'b0;
        waits    = 0;
        errors   = 0;
        checks   = 0;
        next_idx = 0;
        idle     = 0;
        load_trace();

        repeat (5) begin
            @(posedge clk);
            #2;
            check_val("wb_cyc_o", wb_cyc, 1'b0);
            check_val("wb_stb_o", wb_stb, 1'b0);
            check_val("retire_o.valid", retire.valid, 1'b0);
        end
        rstn = 1'b1;
        #1;
        check_val("wb_cyc_o", wb_cyc, 1'b0);
        check_val("wb_stb_o", wb_stb, 1'b0);
        check_val("retire_o.valid", retire.valid, 1'b0);

        start_cnt = 0;
        while (!wb_cyc && start_cnt < START_TIMEOUT) begin
            step_cycle();
            start_cnt++;
        end
        if (!wb_cyc) begin
            $display("Error at %0t: the first fetch never started after reset", $time);
            errors++;
        end else begin
            check_val("wb_adr_o", wb_adr, `RESET_PC);
        end

        idle = 0;
        while (next_idx < exp_pc.size() && idle < RETIRE_TIMEOUT) begin
            step_cycle();
        end
        if (next_idx < exp_pc.size()) begin
            $display("Error at %0t: timed out waiting for retire %0d of %0d",
                     $time, next_idx + 1, exp_pc.size());
            errors++;
        end

        errors += dut_i.props_i.fail_cnt;
        $display("Retires matched: %0d, checks: %0d, errors: %0d", next_idx, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* core_props.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rv_consts.svh"

module core_props
    import rv_pkg::*;
(
    input logic             clk,
    input logic             rstn,
    input logic             cyc_i,
    input logic             stb_i,
    input logic [`XLEN-1:0] adr_i,
    input logic             ack_i,
    input logic             flush_i,
    input retire_s          retire_i
);

    logic stale_q;
    logic fetch_taken;
    int   fail_cnt = 0;

    // Fetch whose data the core drops after a redirect
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            stale_q <= 1'b0;
        end else if (cyc_i && ack_i) begin
            stale_q <= 1'b0;
        end else if (flush_i) begin
            stale_q <= 1'b1;
        end
    end

    assign fetch_taken = cyc_i && ack_i && !stale_q && !flush_i;

    stb_in_cyc: assert property (@(posedge clk) disable iff (!rstn) stb_i |-> cyc_i)
        else begin
            fail_cnt++;
            $error("wb_stb_o high without wb_cyc_o");
        end

    adr_hold: assert property (@(posedge clk) disable iff (!rstn)
        stb_i && !ack_i |=> stb_i && $stable(adr_i))
        else begin
            fail_cnt++;
            $error("fetch dropped or address changed before ack");
        end

    // Decode flush one edge later still kills the word
    retire_latency: assert property (@(posedge clk) disable iff (!rstn)
        fetch_taken ##1 !flush_i |-> ##2 retire_i.valid)
        else begin
            fail_cnt++;
            $error("accepted fetch did not retire three edges after its ack");
        end

endmodule

bind core_top core_props props_i (
    .clk      (clk),
    .rstn     (rstn),
    .cyc_i    (wb_cyc_o),
    .stb_i    (wb_stb_o),
    .adr_i    (wb_adr_o),
    .ack_i    (wb_ack_i),
    .flush_i  (flush),
    .retire_i (retire_o)
);

`default_nettype wire

/* core_top.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rv_consts.svh"

module core_top
    import rv_pkg::*;
(
    input  logic             clk,
    input  logic             rstn,
    output logic             wb_cyc_o,
    output logic             wb_stb_o,
    output logic [`XLEN-1:0] wb_adr_o,
    input  logic [`XLEN-1:0] wb_dat_i,
    input  logic             wb_ack_i,
    output retire_s          retire_o
);

    if_id_s           if_id;
    id_ex_s           id_ex;
    reg_addr_t        rs1_addr;
    reg_addr_t        rs2_addr;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic             redirect;
    logic [`XLEN-1:0] target;
    logic             flush;
    fwd_e             fwd_rs1;
    fwd_e             fwd_rs2;

    fetch_unit fetch_i (
        .clk        (clk),
        .rstn       (rstn),
        .wb_cyc_o   (wb_cyc_o),
        .wb_stb_o   (wb_stb_o),
        .wb_adr_o   (wb_adr_o),
        .wb_dat_i   (wb_dat_i),
        .wb_ack_i   (wb_ack_i),
        .redirect_i (redirect),
        .target_i   (target),
        .flush_i    (flush),
        .if_id_o    (if_id)
    );

    decode_unit decode_i (
        .clk        (clk),
        .rstn       (rstn),
        .if_id_i    (if_id),
        .flush_i    (flush),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .id_ex_o    (id_ex)
    );

    // Written from the retire record
    reg_file rf_i (
        .clk        (clk),
        .rstn       (rstn),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wr_i       (retire_o)
    );

    exec_unit exec_i (
        .clk        (clk),
        .rstn       (rstn),
        .id_ex_i    (id_ex),
        .fwd_rs1_i  (fwd_rs1),
        .fwd_rs2_i  (fwd_rs2),
        .redirect_o (redirect),
        .target_o   (target),
        .retire_o   (retire_o)
    );

    pipe_ctrl ctrl_i (
        .id_ex_i    (id_ex),
        .wb_i       (retire_o),
        .redirect_i (redirect),
        .fwd_rs1_o  (fwd_rs1),
        .fwd_rs2_o  (fwd_rs2),
        .flush_o    (flush)
    );

endmodule

`default_nettype wire

/* pipe_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module pipe_ctrl
    import rv_pkg::*;
(
    input  id_ex_s  id_ex_i,
    input  retire_s wb_i,
    input  logic    redirect_i,
    output fwd_e    fwd_rs1_o,
    output fwd_e    fwd_rs2_o,
    output logic    flush_o
);

    logic wb_live;

    // Writeback record that will land in a real register
    assign wb_live = wb_i.valid && wb_i.we && (wb_i.rd != '0);

    always_comb begin
        fwd_rs1_o = FWD_NONE;
        fwd_rs2_o = FWD_NONE;
        if (wb_live && (wb_i.rd == id_ex_i.rs1)) begin
            fwd_rs1_o = FWD_WB;
        end
        if (wb_live && (wb_i.rd == id_ex_i.rs2)) begin
            fwd_rs2_o = FWD_WB;
        end
    end

    // Taken control flow kills everything younger than execute
    assign flush_o = redirect_i;

endmodule

`default_nettype wire

/* exec_unit.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rv_consts.svh"

module exec_unit
    import rv_pkg::*;
(
    input  logic             clk,
    input  logic             rstn,
    input  id_ex_s           id_ex_i,
    input  fwd_e             fwd_rs1_i,
    input  fwd_e             fwd_rs2_i,
    output logic             redirect_o,
    output logic [`XLEN-1:0] target_o,
    output retire_s          retire_o
);

    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] link;
    logic [`XLEN-1:0] pc_rel;
    logic [`XLEN-1:0] jalr_sum;
    logic [`XLEN-1:0] res;
    logic             taken;

    // Operand select, writeback result wins on a match
    assign a = (fwd_rs1_i == FWD_WB) ? retire_o.rd_data : id_ex_i.rs1_data;
    assign b = (fwd_rs2_i == FWD_WB) ? retire_o.rd_data : id_ex_i.rs2_data;

    assign imm      = id_ex_i.imm;
    assign link     = id_ex_i.pc + 32'd4;
    assign pc_rel   = id_ex_i.pc + imm;
    assign jalr_sum = a + imm;

    always_comb begin
        res      = '0;
        taken    = 1'b0;
        target_o = pc_rel;
        case (id_ex_i.op)
            LUI:   res = imm;
            AUIPC: res = pc_rel;
            JAL: begin
                res   = link;
                taken = 1'b1;
            end
            JALR: begin
                res      = link;
                taken    = 1'b1;
                target_o = {jalr_sum[`XLEN-1:1], 1'b0};
            end
            BEQ:   taken = (a == b);
            BNE:   taken = (a != b);
            BLT:   taken = ($signed(a) < $signed(b));
            BGE:   taken = ($signed(a) >= $signed(b));
            BLTU:  taken = (a < b);
            BGEU:  taken = (a >= b);
            ADDI:  res = a + imm;
            SLTI:  res = `XLEN'($signed(a) < $signed(imm));
            SLTIU: res = `XLEN'(a < imm);
            XORI:  res = a ^ imm;
            ORI:   res = a | imm;
            ANDI:  res = a & imm;
            SLLI:  res = a << imm[4:0];
            SRLI:  res = a >> imm[4:0];
            SRAI:  res = $unsigned($signed(a) >>> imm[4:0]);
            ADD:   res = a + b;
            SUB:   res = a - b;
            SLL:   res = a << b[4:0];
            SLT:   res = `XLEN'($signed(a) < $signed(b));
            SLTU:  res = `XLEN'(a < b);
            XOR:   res = a ^ b;
            SRL:   res = a >> b[4:0];
            SRA:   res = $unsigned($signed(a) >>> b[4:0]);
            OR:    res = a | b;
            AND:   res = a & b;
            default: res = '0;
        endcase
    end

    assign redirect_o = id_ex_i.valid && taken;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            retire_o <= '0;
        end else begin
            retire_o.valid   <= id_ex_i.valid;
            retire_o.pc      <= id_ex_i.pc;
            retire_o.instr   <= id_ex_i.instr;
            retire_o.rd      <= id_ex_i.rd;
            retire_o.we      <= id_ex_i.we;
            retire_o.rd_data <= res;
        end
    end

endmodule

`default_nettype wire

/* reg_file.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rv_consts.svh"

module reg_file
    import rv_pkg::*;
(
    input  logic             clk,
    input  logic             rstn,
    input  reg_addr_t        rs1_addr_i,
    input  reg_addr_t        rs2_addr_i,
    output logic [`XLEN-1:0] rs1_data_o,
    output logic [`XLEN-1:0] rs2_data_o,
    input  retire_s          wr_i
);

    logic [`XLEN-1:0] regs [`NREGS];
    logic             wr_en;

    // x0 is never written, so it stays at its reset value
    assign wr_en = wr_i.valid && wr_i.we && (wr_i.rd != '0);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_i.rd] <= wr_i.rd_data;
        end
    end

    // Same-cycle write shows through on read
    assign rs1_data_o = (wr_en && (wr_i.rd == rs1_addr_i)) ? wr_i.rd_data : regs[rs1_addr_i];
    assign rs2_data_o = (wr_en && (wr_i.rd == rs2_addr_i)) ? wr_i.rd_data : regs[rs2_addr_i];

endmodule

`default_nettype wire

/* decode_unit.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rv_consts.svh"

module decode_unit
    import rv_pkg::*;
(
    input  logic             clk,
    input  logic             rstn,
    input  if_id_s           if_id_i,
    input  logic             flush_i,
    output reg_addr_t        rs1_addr_o,
    output reg_addr_t        rs2_addr_o,
    input  logic [`XLEN-1:0] rs1_data_i,
    input  logic [`XLEN-1:0] rs2_data_i,
    output id_ex_s           id_ex_o
);

    instr_u           ins;
    op_e              op;
    logic [`XLEN-1:0] imm;
    logic             we;

    assign ins        = if_id_i.instr;
    assign rs1_addr_o = ins.r_fmt.rs1;
    assign rs2_addr_o = ins.r_fmt.rs2;

    always_comb begin
        op  = OP_NONE;
        imm = {{20{ins.i_fmt.imm12[11]}}, ins.i_fmt.imm12};
        we  = 1'b1;
        case (ins.r_fmt.opcode)
            `OP_LUI: begin
                op  = LUI;
                imm = {ins.u_fmt.imm20, 12'b0};
            end
            `OP_AUIPC: begin
                op  = AUIPC;
                imm = {ins.u_fmt.imm20, 12'b0};
            end
            `OP_JAL: begin
                op  = JAL;
                imm = {{12{ins.sb_fmt.imm_sign}}, ins.sb_fmt.imm_19_12, ins.sb_fmt.imm_11j,
                       ins.sb_fmt.imm_10_5, ins.sb_fmt.imm_4_1j, 1'b0};
            end
            `OP_JALR: op = JALR;
            `OP_BRANCH: begin
                we  = 1'b0;
                imm = {{20{ins.sb_fmt.imm_sign}}, ins.sb_fmt.imm_11b,
                       ins.sb_fmt.imm_10_5, ins.sb_fmt.imm_4_1b, 1'b0};
                case (ins.r_fmt.funct3)
                    `F3_BEQ:  op = BEQ;
                    `F3_BNE:  op = BNE;
                    `F3_BLT:  op = BLT;
                    `F3_BGE:  op = BGE;
                    `F3_BLTU: op = BLTU;
                    `F3_BGEU: op = BGEU;
                    default:  op = OP_NONE;
                endcase
            end
            `OP_IMM: begin
                case (ins.r_fmt.funct3)
                    `F3_ADD_SUB: op = ADDI;
                    `F3_SLT:     op = SLTI;
                    `F3_SLTU:    op = SLTIU;
                    `F3_XOR:     op = XORI;
                    `F3_OR:      op = ORI;
                    `F3_AND:     op = ANDI;
                    `F3_SLL:     op = (ins.r_fmt.funct7 == `F7_BASE) ? SLLI : OP_NONE;
                    default: begin
                        if (ins.r_fmt.funct7 == `F7_BASE) begin
                            op = SRLI;
                        end else if (ins.r_fmt.funct7 == `F7_ALT) begin
                            op = SRAI;
                        end
                    end
                endcase
            end
            `OP_REG: begin
                if (ins.r_fmt.funct7 == `F7_BASE) begin
                    case (ins.r_fmt.funct3)
                        `F3_ADD_SUB: op = ADD;
                        `F3_SLL:     op = SLL;
                        `F3_SLT:     op = SLT;
                        `F3_SLTU:    op = SLTU;
                        `F3_XOR:     op = XOR;
                        `F3_SRL_SRA: op = SRL;
                        `F3_OR:      op = OR;
                        default:     op = AND;
                    endcase
                end else if (ins.r_fmt.funct7 == `F7_ALT) begin
                    if (ins.r_fmt.funct3 == `F3_ADD_SUB) begin
                        op = SUB;
                    end else if (ins.r_fmt.funct3 == `F3_SRL_SRA) begin
                        op = SRA;
                    end
                end
            end
            default: op = OP_NONE;
        endcase
        // Unknown encodings never write
        if (op == OP_NONE) begin
            we = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            id_ex_o <= '0;
        end else begin
            id_ex_o.valid    <= if_id_i.valid && !flush_i;
            id_ex_o.pc       <= if_id_i.pc;
            id_ex_o.instr    <= ins;
            id_ex_o.op       <= op;
            id_ex_o.imm      <= imm;
            id_ex_o.rs1      <= ins.r_fmt.rs1;
            id_ex_o.rs2      <= ins.r_fmt.rs2;
            id_ex_o.rs1_data <= rs1_data_i;
            id_ex_o.rs2_data <= rs2_data_i;
            id_ex_o.rd       <= ins.r_fmt.rd;
            id_ex_o.we       <= we;
        end
    end

endmodule

`default_nettype wire

/* fetch_unit.sv */
`timescale 1ns/100ps
`default_nettype none
`include "rv_consts.svh"

module fetch_unit
    import rv_pkg::*;
(
    input  logic             clk,
    input  logic             rstn,
    output logic             wb_cyc_o,
    output logic             wb_stb_o,
    output logic [`XLEN-1:0] wb_adr_o,
    input  logic [`XLEN-1:0] wb_dat_i,
    input  logic             wb_ack_i,
    input  logic             redirect_i,
    input  logic [`XLEN-1:0] target_i,
    input  logic             flush_i,
    output if_id_s           if_id_o
);

    logic             cyc_q;
    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] next_pc_q;
    logic             stale_q;
    logic             done;
    logic             take;

    assign done = cyc_q && wb_ack_i;
    // Word arrived on the right path
    assign take = done && !stale_q && !flush_i;

    assign wb_cyc_o = cyc_q;
    assign wb_stb_o = cyc_q;
    assign wb_adr_o = {pc_q[`XLEN-1:2], 2'b00};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cyc_q     <= 1'b0;
            pc_q      <= `RESET_PC;
            next_pc_q <= `RESET_PC;
            stale_q   <= 1'b0;
        end else begin
            cyc_q <= 1'b1;
            if (done) begin
                stale_q <= 1'b0;
                if (redirect_i) begin
                    pc_q <= target_i;
                end else if (stale_q) begin
                    pc_q <= next_pc_q;
                end else begin
                    pc_q <= pc_q + 32'd4;
                end
            end else if (redirect_i) begin
                // Address must hold until ack, so park the target
                stale_q   <= 1'b1;
                next_pc_q <= target_i;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            if_id_o <= '0;
        end else begin
            if_id_o.valid <= take;
            if_id_o.pc    <= pc_q;
            if (done) begin
                if_id_o.instr <= wb_dat_i;
            end
        end
    end

endmodule

`default_nettype wire

/* rv_pkg.sv */
`default_nettype none
`include "rv_consts.svh"

package rv_pkg;

    typedef logic [$clog2(`NREGS)-1:0] reg_addr_t;

    // Same 32-bit word, seen through each encoding
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            logic [2:0] funct3;
            reg_addr_t  rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm12;
            reg_addr_t   rs1;
            logic [2:0]  funct3;
            reg_addr_t   rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [19:0] imm20;
            reg_addr_t   rd;
            logic [6:0]  opcode;
        } u_fmt;
        // Immediate pieces of B and J types
        struct packed {
            logic       imm_sign;
            logic [5:0] imm_10_5;
            logic [3:0] imm_4_1j;
            logic       imm_11j;
            logic [7:0] imm_19_12;
            logic [3:0] imm_4_1b;
            logic       imm_11b;
            logic [6:0] opcode;
        } sb_fmt;
    } instr_u;

    typedef enum logic [4:0] {
        OP_NONE,
        LUI, AUIPC, JAL, JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI,
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } op_e;

    typedef enum logic {
        FWD_NONE,
        FWD_WB
    } fwd_e;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        instr_u           instr;
    } if_id_s;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        instr_u           instr;
        op_e              op;
        logic [`XLEN-1:0] imm;
        reg_addr_t        rs1;
        reg_addr_t        rs2;
        logic [`XLEN-1:0] rs1_data;
        logic [`XLEN-1:0] rs2_data;
        reg_addr_t        rd;
        logic             we;
    } id_ex_s;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        instr_u           instr;
        reg_addr_t        rd;
        logic             we;
        logic [`XLEN-1:0] rd_data;
    } retire_s;

endpackage

`default_nettype wire

/* rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define XLEN       32
`define RESET_PC   32'h8000_0000
`define NREGS      32

// Major opcodes
`define OP_LUI     7'b0110111
`define OP_AUIPC   7'b0010111
`define OP_JAL     7'b1101111
`define OP_JALR    7'b1100111
`define OP_BRANCH  7'b1100011
`define OP_IMM     7'b0010011
`define OP_REG     7'b0110011

// ALU funct3, shared by register and immediate forms
`define F3_ADD_SUB 3'b000
`define F3_SLL     3'b001
`define F3_SLT     3'b010
`define F3_SLTU    3'b011
`define F3_XOR     3'b100
`define F3_SRL_SRA 3'b101
`define F3_OR      3'b110
`define F3_AND     3'b111

// Branch funct3
`define F3_BEQ     3'b000
`define F3_BNE     3'b001
`define F3_BLT     3'b100
`define F3_BGE     3'b101
`define F3_BLTU    3'b110
`define F3_BGEU    3'b111

`define F7_BASE    7'b0000000
`define F7_ALT     7'b0100000

`endif
